//--- common/sifhPkg.sv
`default_nettype none

package sifhPkg;

    localparam int tsBits = 16;  // TDC timestamp width
    localparam int binBits = 6;  // histogram index width
    localparam int cntBits = 12;  // bin count width, saturating
    localparam int binNum = 1 << binBits;

    // bit positions of the two bin fields inside a timestamp
    localparam int coarseLsb = tsBits - binBits;
    localparam int fineLsb = tsBits - 2 * binBits;

    typedef struct packed {
        logic [15:0] samplesPerPass;  // TDC samples per pass
    } sifhCfg;

    typedef struct packed {
        logic [binBits-1:0] coarseBin;
        logic [cntBits-1:0] coarseCount;
        logic [binBits-1:0] fineBin;
        logic [cntBits-1:0] fineCount;
    } sifhResult;

    typedef struct packed {
        logic               we;
        logic [binBits-1:0] addr;
        logic [cntBits-1:0] wdata;
    } ramWrPort;

    typedef struct packed {
        logic               re;
        logic [binBits-1:0] addr;
    } ramRdPort;

    typedef enum logic [3:0] {
        stIdle,
        stClear1,
        stBuild1,
        stFind1,
        stFilter,
        stClear2,
        stBuild2,
        stFind2,
        stDone
    } seqState;

endpackage

`default_nettype wire

//--- hw/histRam.sv
`timescale 1ns/1ps
`default_nettype none

// behavioral dual-port histogram memory
// write port and read port are independent, read data comes one cycle after re
module histRam (
    input  wire logic                        clk,
    input  wire sifhPkg::ramWrPort           wr,
    input  wire sifhPkg::ramRdPort           rd,
    output logic [sifhPkg::cntBits-1:0]      rdata
);

    logic [sifhPkg::cntBits-1:0] mem [sifhPkg::binNum];  // one word per bin

    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr.addr] <= wr.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rd.re) begin
            rdata <= mem[rd.addr];  // registered read
        end
    end

endmodule

`default_nettype wire

//--- histBuilder/histBuilder.sv
`timescale 1ns/1ps
`default_nettype none

module histBuilder (
    input  wire logic                        clk,
    input  wire logic                        res,
    input  wire logic                        buildEn,
    input  wire logic                        finePass,
    input  wire logic [sifhPkg::binBits-1:0] fineKey,
    input  wire logic [15:0]                 samplesPerPass,
    input  wire logic                        tdcReq,
    input  wire logic [sifhPkg::tsBits-1:0]  tdcData,
    input  wire logic [sifhPkg::cntBits-1:0] rdata,
    output logic                             tdcAck,
    output logic                             buildDone,
    output sifhPkg::ramWrPort                wr,
    output sifhPkg::ramRdPort                rd
);

    typedef enum logic [1:0] {bIdle, bRead, bWrite, bAck} bState;

    bState                        state;
    logic [sifhPkg::binBits-1:0]  binQ;      // bin of the captured sample
    logic [15:0]                  handled;   // counted or discarded samples
    logic                         doneSent;
    logic [sifhPkg::binBits-1:0]  topField;
    logic [sifhPkg::binBits-1:0]  lowField;
    logic                         keep;
    logic [sifhPkg::cntBits-1:0]  incCount;

    assign topField = tdcData[sifhPkg::coarseLsb +: sifhPkg::binBits];
    assign lowField = tdcData[sifhPkg::fineLsb +: sifhPkg::binBits];
    assign keep = !finePass || (topField == fineKey);  // fine pass filter
    assign incCount = (&rdata) ? rdata : rdata + 1'b1;  // saturate at all ones

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= bIdle;
            tdcAck <= 1'b0;
            buildDone <= 1'b0;
            handled <= '0;
            doneSent <= 1'b0;
        end else begin
            buildDone <= 1'b0;
            case (state)
                bIdle: begin
                    if (!buildEn) begin
                        handled <= '0;  // rearm for the next pass
                        doneSent <= 1'b0;
                    end else if (handled == samplesPerPass) begin
                        if (!doneSent) begin
                            buildDone <= 1'b1;
                            doneSent <= 1'b1;
                        end
                    end else if (tdcReq) begin
                        handled <= handled + 1'b1;
                        if (keep) begin
                            state <= bRead;
                        end else begin
                            tdcAck <= 1'b1;  // discarded, ack right away
                            state <= bAck;
                        end
                    end
                end
                bRead: state <= bWrite;
                bWrite: begin
                    tdcAck <= 1'b1;
                    state <= bAck;
                end
                bAck: begin
                    if (!tdcReq) begin
                        tdcAck <= 1'b0;
                        state <= bIdle;
                    end
                end
                default: state <= bIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == bIdle && tdcReq) begin
            binQ <= finePass ? lowField : topField;
        end
    end

    always_comb begin
        rd.re = (state == bRead);
        rd.addr = binQ;
        wr.we = (state == bWrite);  // rdata of binQ is valid here
        wr.addr = binQ;
        wr.wdata = incCount;
    end

endmodule

`default_nettype wire

//--- peakFinder/peakFinder.sv
`timescale 1ns/1ps
`default_nettype none

// scans all bins in order and keeps the largest count
module peakFinder (
    input  wire logic                        clk,
    input  wire logic                        res,
    input  wire logic                        findStart,
    input  wire logic [sifhPkg::cntBits-1:0] rdata,
    output sifhPkg::ramRdPort                rd,
    output logic                             findDone,
    output logic [sifhPkg::binBits-1:0]      peakBin,
    output logic [sifhPkg::cntBits-1:0]      peakCount
);

    logic                         busy;   // read phase active
    logic [sifhPkg::binBits-1:0]  addr;   // next bin to read
    logic                         vQ;     // rdata holds a bin this cycle
    logic [sifhPkg::binBits-1:0]  binD;   // bin that rdata belongs to

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            busy <= 1'b0;
            addr <= '0;
            vQ <= 1'b0;
            findDone <= 1'b0;
        end else begin
            vQ <= busy;
            findDone <= vQ && (&binD);  // last bin compared
            if (findStart) begin
                busy <= 1'b1;
                addr <= '0;
            end else if (busy) begin
                addr <= addr + 1'b1;
                if (&addr) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        binD <= addr;
    end

    // strictly larger wins, so ties keep the lower bin
    always_ff @(posedge clk) begin
        if (vQ) begin
            if (binD == '0) begin
                peakBin <= '0;
                peakCount <= rdata;
            end else if (rdata > peakCount) begin
                peakBin <= binD;
                peakCount <= rdata;
            end
        end
    end

    always_comb begin
        rd.re = busy;
        rd.addr = addr;
    end

endmodule

`default_nettype wire

//--- hw/sifhSeq.sv
`timescale 1ns/1ps
`default_nettype none

module sifhSeq (
    input  wire logic                        clk,
    input  wire logic                        res,
    input  wire logic                        start,
    input  wire logic [15:0]                 samplesPerPass,
    input  wire logic                        buildDone,
    input  wire logic                        findDone,
    input  wire logic [sifhPkg::binBits-1:0] peakBin,
    input  wire sifhPkg::ramWrPort           builderWr,
    input  wire sifhPkg::ramRdPort           builderRd,
    input  wire sifhPkg::ramRdPort           finderRd,
    output logic                             buildEn,
    output logic                             finePass,
    output logic [sifhPkg::binBits-1:0]      fineKey,
    output logic [15:0]                      samplesOut,
    output logic                             findStart,
    output sifhPkg::ramWrPort                ramWr,
    output sifhPkg::ramRdPort                ramRd,
    output logic                             coarseValid,
    output logic                             fineValid,
    output logic                             measDone
);

    sifhPkg::seqState             state;
    logic [sifhPkg::binBits-1:0]  clrAddr;  // clear address counter
    logic                         clearing;
    logic                         building;
    logic                         finding;

    assign clearing = (state == sifhPkg::stClear1) || (state == sifhPkg::stClear2);
    assign building = (state == sifhPkg::stBuild1) || (state == sifhPkg::stBuild2);
    assign finding = (state == sifhPkg::stFind1) || (state == sifhPkg::stFind2);

    assign buildEn = building;
    assign finePass = (state == sifhPkg::stBuild2);
    assign coarseValid = (state == sifhPkg::stFind1) && findDone;
    assign fineValid = (state == sifhPkg::stFind2) && findDone;
    assign measDone = (state == sifhPkg::stDone);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= sifhPkg::stIdle;
            clrAddr <= '0;
            fineKey <= '0;
            findStart <= 1'b0;
            samplesOut <= '0;
        end else begin
            findStart <= building && buildDone;  // finder starts with the find state
            if (clearing) begin
                clrAddr <= clrAddr + 1'b1;
            end
            case (state)
                sifhPkg::stIdle: begin
                    if (start) begin
                        samplesOut <= samplesPerPass;
                        clrAddr <= '0;
                        state <= sifhPkg::stClear1;
                    end
                end
                sifhPkg::stClear1: if (&clrAddr) state <= sifhPkg::stBuild1;
                sifhPkg::stBuild1: if (buildDone) state <= sifhPkg::stFind1;
                sifhPkg::stFind1: if (findDone) state <= sifhPkg::stFilter;
                sifhPkg::stFilter: begin
                    fineKey <= peakBin;  // coarse peak selects the fine window
                    clrAddr <= '0;
                    state <= sifhPkg::stClear2;
                end
                sifhPkg::stClear2: if (&clrAddr) state <= sifhPkg::stBuild2;
                sifhPkg::stBuild2: if (buildDone) state <= sifhPkg::stFind2;
                sifhPkg::stFind2: if (findDone) state <= sifhPkg::stDone;
                sifhPkg::stDone: state <= sifhPkg::stIdle;
                default: state <= sifhPkg::stIdle;
            endcase
        end
    end

    // one memory client at a time, chosen by state
    always_comb begin
        ramWr = '0;
        ramRd = '0;
        if (clearing) begin
            ramWr.we = 1'b1;
            ramWr.addr = clrAddr;
            ramWr.wdata = '0;
        end else if (building) begin
            ramWr = builderWr;
            ramRd = builderRd;
        end else if (finding) begin
            ramRd = finderRd;
        end
    end

endmodule

`default_nettype wire

//--- hw/sifhRegs.sv
`timescale 1ns/1ps
`default_nettype none

// host command handshake plus configuration and result holding
module sifhRegs (
    input  wire logic                        clk,
    input  wire logic                        res,
    input  wire logic                        cmdReq,
    input  wire sifhPkg::sifhCfg             cfg,
    input  wire logic                        coarseValid,
    input  wire logic                        fineValid,
    input  wire logic [sifhPkg::binBits-1:0] peakBin,
    input  wire logic [sifhPkg::cntBits-1:0] peakCount,
    input  wire logic                        measDone,
    output logic                             cmdAck,
    output logic                             start,
    output sifhPkg::sifhCfg                  cfgQ,
    output sifhPkg::sifhResult               result
);

    logic busy;  // measurement in flight
    logic take;

    assign take = cmdReq && !cmdAck && !busy;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            cmdAck <= 1'b0;
            start <= 1'b0;
            busy <= 1'b0;
        end else begin
            start <= take;
            if (take) begin
                busy <= 1'b1;
            end else if (measDone) begin
                busy <= 1'b0;
                cmdAck <= 1'b1;  // result is complete now
            end else if (cmdAck && !cmdReq) begin
                cmdAck <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            cfgQ <= cfg;
        end
        if (coarseValid) begin
            result.coarseBin <= peakBin;
            result.coarseCount <= peakCount;
        end
        if (fineValid) begin
            result.fineBin <= peakBin;
            result.fineCount <= peakCount;
        end
    end

endmodule

`default_nettype wire

//--- hw/sifhTop.sv
`timescale 1ns/1ps
`default_nettype none

module sifhTop (
    input  wire logic                        clk,
    input  wire logic                        res,
    input  wire logic                        cmdReq,
    input  wire sifhPkg::sifhCfg             cfg,
    output logic                             cmdAck,
    output sifhPkg::sifhResult               result,
    input  wire logic                        tdcReq,
    input  wire logic [sifhPkg::tsBits-1:0]  tdcData,
    output logic                             tdcAck
);

    sifhPkg::sifhCfg              cfgQ;
    sifhPkg::ramWrPort            builderWr;
    sifhPkg::ramRdPort            builderRd;
    sifhPkg::ramRdPort            finderRd;
    sifhPkg::ramWrPort            ramWr;
    sifhPkg::ramRdPort            ramRd;
    logic [sifhPkg::cntBits-1:0]  rdata;
    logic [sifhPkg::binBits-1:0]  peakBin;
    logic [sifhPkg::cntBits-1:0]  peakCount;
    logic [sifhPkg::binBits-1:0]  fineKey;
    logic [15:0]                  samples;
    logic start, buildEn, finePass, buildDone, findStart, findDone;
    logic coarseValid, fineValid, measDone;

    sifhRegs regs_i (
        .clk(clk), .res(res), .cmdReq(cmdReq), .cfg(cfg),
        .coarseValid(coarseValid), .fineValid(fineValid),
        .peakBin(peakBin), .peakCount(peakCount), .measDone(measDone),
        .cmdAck(cmdAck), .start(start), .cfgQ(cfgQ), .result(result)
    );

    sifhSeq seq_i (
        .clk(clk), .res(res), .start(start), .samplesPerPass(cfgQ.samplesPerPass),
        .buildDone(buildDone), .findDone(findDone), .peakBin(peakBin),
        .builderWr(builderWr), .builderRd(builderRd), .finderRd(finderRd),
        .buildEn(buildEn), .finePass(finePass), .fineKey(fineKey),
        .samplesOut(samples), .findStart(findStart), .ramWr(ramWr), .ramRd(ramRd),
        .coarseValid(coarseValid), .fineValid(fineValid), .measDone(measDone)
    );

    histBuilder builder_i (
        .clk(clk), .res(res), .buildEn(buildEn), .finePass(finePass),
        .fineKey(fineKey), .samplesPerPass(samples), .tdcReq(tdcReq),
        .tdcData(tdcData), .rdata(rdata), .tdcAck(tdcAck),
        .buildDone(buildDone), .wr(builderWr), .rd(builderRd)
    );

    peakFinder finder_i (
        .clk(clk), .res(res), .findStart(findStart), .rdata(rdata),
        .rd(finderRd), .findDone(findDone), .peakBin(peakBin), .peakCount(peakCount)
    );

    histRam ram_i (
        .clk(clk), .wr(ramWr), .rd(ramRd), .rdata(rdata)
    );

endmodule

`default_nettype wire

//--- tests/clkGen.sv
`timescale 1ns/1ps
`default_nettype none

// 20 ns clock, reset held low for the first two cycles
module clkGen (
    output logic clk,
    output logic res
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        res = 1'b0;
        repeat (2) @(posedge clk);
        #2 res = 1'b1;  // released off the edge like other inputs
    end

endmodule

`default_nettype wire

//--- tests/sifhTb.sv
`timescale 1ns/1ps
`default_nettype none

module sifhTb;

    typedef struct packed {
        logic [15:0] samples;  // samplesPerPass
        logic [15:0] peakTs;   // dominant timestamp
        logic [15:0] repeats;  // samples that repeat peakTs
        logic        noise;    // random rest when set, fillTs otherwise
        logic [15:0] fillTs;
    } caseRow;

    localparam int caseNum = 7;

    localparam caseRow caseTable [caseNum] = '{
        '{16'd20,   16'hA5C3, 16'd20,   1'b0, 16'h0000},  // single timestamp
        '{16'd60,   16'h3E7A, 16'd30,   1'b1, 16'h0000},  // peak in noise
        '{16'd16,   16'hC840, 16'd8,    1'b0, 16'h1D20},  // coarse tie won by bin 7
        '{16'd16,   16'h5570, 16'd8,    1'b0, 16'h5410},  // fine tie in one coarse bin
        '{16'd40,   16'h8888, 16'd24,   1'b1, 16'h0000},  // noise mostly filtered
        '{16'd4100, 16'h0F0F, 16'd4100, 1'b0, 16'h0000},  // saturation
        '{16'd10,   16'h0F0F, 16'd6,    1'b1, 16'h0000}   // same bins after saturation
    };

    logic               clk;
    logic               res;
    logic               cmdReq;
    sifhPkg::sifhCfg    cfg;
    logic               cmdAck;
    sifhPkg::sifhResult result;
    logic               tdcReq;
    logic [15:0]        tdcData;
    logic               tdcAck;

    logic [15:0] coarseList [$];
    logic [15:0] fineList [$];
    int          refHist [64];  // reference histogram
    int          cycleCount = 0;
    int          cycleLimit;

    clkGen clkGen_i (.clk(clk), .res(res));

    sifhTop dut_i (
        .clk(clk), .res(res), .cmdReq(cmdReq), .cfg(cfg), .cmdAck(cmdAck),
        .result(result), .tdcReq(tdcReq), .tdcData(tdcData), .tdcAck(tdcAck)
    );

    task automatic stepCycle;
        @(posedge clk);
        #2;
    endtask

    task automatic checkResult(input sifhPkg::sifhResult got, input sifhPkg::sifhResult exp);
        if (got !== exp) begin
            $display("error result coarseBin %h coarseCount %h fineBin %h fineCount %h",
                     got.coarseBin, got.coarseCount, got.fineBin, got.fineCount);
            $display("error result expected %h %h %h %h",
                     exp.coarseBin, exp.coarseCount, exp.fineBin, exp.fineCount);
            $display("=== FAIL ===");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic checkAck(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "handshake mismatch");
        end
    endtask

    // four-phase TDC handshake for one sample
    task automatic sendSample(input logic [15:0] ts);
        tdcData = ts;
        tdcReq = 1'b1;
        stepCycle();
        while (!tdcAck) stepCycle();
        tdcReq = 1'b0;
        stepCycle();
        while (tdcAck) stepCycle();
    endtask

    task automatic clearHist;
        foreach (refHist[i]) refHist[i] = 0;
    endtask

    task automatic countBin(input int b);
        if (refHist[b] < 4095) begin
            refHist[b]++;  // saturating count
        end
    endtask

    // lowest bin wins a tie
    task automatic pickPeak(output logic [5:0] bin, output logic [11:0] cnt);
        int best;
        best = 0;
        for (int b = 1; b < 64; b++) begin
            if (refHist[b] > refHist[best]) best = b;
        end
        bin = 6'(best);
        cnt = 12'(refHist[best]);
    endtask

    task automatic modelExpected(output sifhPkg::sifhResult exp);
        logic [5:0]  cBin;
        logic [11:0] cCnt;
        logic [5:0]  fBin;
        logic [11:0] fCnt;
        clearHist();
        foreach (coarseList[i]) countBin(int'(coarseList[i][15:10]));
        pickPeak(cBin, cCnt);
        clearHist();
        foreach (fineList[i]) begin
            if (fineList[i][15:10] == cBin) countBin(int'(fineList[i][9:4]));
        end
        pickPeak(fBin, fCnt);
        exp.coarseBin = cBin;
        exp.coarseCount = cCnt;
        exp.fineBin = fBin;
        exp.fineCount = fCnt;
    endtask

    function automatic logic [15:0] otherTs(input caseRow c);
        return c.noise ? 16'($urandom()) : c.fillTs;
    endfunction

    task automatic buildLists(input caseRow c);
        coarseList.delete();
        fineList.delete();
        for (int i = 0; i < int'(c.samples); i++) begin
            coarseList.push_back((i < int'(c.repeats)) ? c.peakTs : otherTs(c));
            fineList.push_front((i < int'(c.repeats)) ? c.peakTs : otherTs(c));
        end
    endtask

    task automatic runCase(input caseRow c);
        sifhPkg::sifhResult exp;
        buildLists(c);
        modelExpected(exp);
        cfg.samplesPerPass = c.samples;
        cmdReq = 1'b1;
        tdcData = coarseList[0];
        tdcReq = 1'b1;  // first sample waits through the 64 cycle clear
        repeat (32) stepCycle();
        checkAck("tdcAck", tdcAck, 1'b0);
        foreach (coarseList[i]) sendSample(coarseList[i]);
        foreach (fineList[i]) sendSample(fineList[i]);
        while (!cmdAck) stepCycle();
        checkResult(result, exp);
        stepCycle();
        checkAck("cmdAck", cmdAck, 1'b1);  // held while cmdReq stays high
        cmdReq = 1'b0;
        while (cmdAck) stepCycle();
        checkAck("tdcAck", tdcAck, 1'b0);
    endtask

    function automatic int limitCycles;
        int total;
        total = 0;
        foreach (caseTable[i]) total += int'(caseTable[i].samples) * 2 * 10 + 400;
        return total;
    endfunction

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout, the measurements did not finish within %0d cycles", cycleLimit);
            $display("=== FAIL ===");
            $fatal(1, "timeout");
        end
    end

    initial begin
        void'($urandom(32'hff8d75c6));
        cycleLimit = limitCycles();
        cmdReq = 1'b0;
        cfg = '0;
        tdcReq = 1'b0;
        tdcData = '0;
        @(posedge res);
        stepCycle();
        checkAck("cmdAck", cmdAck, 1'b0);
        checkAck("tdcAck", tdcAck, 1'b0);
        // back to back cases without a reset
        foreach (caseTable[i]) begin
            $display("case %0d samplesPerPass %0d", i, caseTable[i].samples);
            runCase(caseTable[i]);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
common/sifhPkg.sv
hw/histRam.sv
histBuilder/histBuilder.sv
peakFinder/peakFinder.sv
hw/sifhSeq.sv
hw/sifhRegs.sv
hw/sifhTop.sv
tests/clkGen.sv
tests/sifhTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f tb.f --top-module sifhTb -o sifhSim

status=0
./obj_dir/sifhSim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "=== PASS ===" sim.log; then
    echo "simulation did not complete"
    exit 1
fi
echo "simulation finished cleanly"
